// File: design/subsys_pkg.sv
`default_nettype none

package subsys_pkg;

   ////////////////////////////////////////////////////////////
   // Bus widths and transfer types
   ////////////////////////////////////////////////////////////
   localparam int HADDR_WIDTH = 32;
   localparam int HDATA_WIDTH = 32;

   typedef enum logic [1:0] {
      HTRANS_IDLE   = 2'b00,
      HTRANS_NONSEQ = 2'b10                           // Only single transfers on this bus
   } htrans_t;

   typedef enum logic [1:0] {SLV_SRAM, SLV_CORDIC0, SLV_CORDIC1, SLV_NONE} slave_idx_t;

   ////////////////////////////////////////////////////////////
   // Address map, match when (addr & mask) == base
   ////////////////////////////////////////////////////////////
   localparam logic [HADDR_WIDTH-1:0] SRAM_BASE    = 32'h0000_0000;
   localparam logic [HADDR_WIDTH-1:0] SRAM_MASK    = 32'hE000_0000;
   localparam logic [HADDR_WIDTH-1:0] CORDIC0_BASE = 32'h4000_0000;
   localparam logic [HADDR_WIDTH-1:0] CORDIC1_BASE = 32'h4000_0100;
   localparam logic [HADDR_WIDTH-1:0] CORDIC_MASK  = 32'hFFFF_FFE0;  // 32 byte window each

   // CORDIC register offsets inside the window
   localparam logic [4:0] CORDIC_REG_ANGLE  = 5'h00;
   localparam logic [4:0] CORDIC_REG_STATUS = 5'h04;  // Bit 0 busy, bit 1 done
   localparam logic [4:0] CORDIC_REG_COS    = 5'h08;
   localparam logic [4:0] CORDIC_REG_SIN    = 5'h0C;

   // atan(2^-i), full turn is 2^32
   localparam logic [31:0] CORDIC_ATAN_TABLE [16] = '{
      32'h2000_0000, 32'h12E4_051D, 32'h09FB_385B, 32'h0511_11D4,
      32'h028B_0D41, 32'h0145_D7E1, 32'h00A2_F61E, 32'h0051_7C55,
      32'h0028_BE4A, 32'h0014_5F2E, 32'h000A_2F98, 32'h0005_17CC,
      32'h0002_8BE6, 32'h0001_45F3, 32'h0000_A2F9, 32'h0000_517C
   };

   localparam logic signed [31:0] CORDIC_GAIN_INIT = 32'sh26DD_3B6A;  // 1/K in Q2.30

   // Read pattern that raises the detector
   localparam logic [HDATA_WIDTH-1:0] SIGNATURE_FIRST  = 32'hA5A5_0F0F;
   localparam logic [HDATA_WIDTH-1:0] SIGNATURE_SECOND = 32'h5A5A_F0F0;

   typedef enum logic [1:0] {DET_IDLE, DET_FIRST, DET_FOUND} det_state_t;
   typedef enum logic [1:0] {CRD_IDLE, CRD_BUSY, CRD_DONE} cordic_state_t;

endpackage

`default_nettype wire

// File: design/cordic_core.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_core import subsys_pkg::*; #(
   parameter int CORDIC_ITERS = 16               // 1 to 16
) (
   input  logic                   hclk_i,
   input  logic                   arst_n_i,
   input  logic                   start_i,
   input  logic [HDATA_WIDTH-1:0] angle_i,       // 2^32 per turn
   output logic                   busy_o,
   output logic                   done_o,
   output logic [HDATA_WIDTH-1:0] cos_o,         // Q2.30
   output logic [HDATA_WIDTH-1:0] sin_o
);

   logic signed [HDATA_WIDTH-1:0] x_q, y_q, z_q;
   logic signed [HDATA_WIDTH-1:0] x_sh, y_sh;
   logic [4:0]                    iter_q;
   logic                          fold;

   // Second or third quadrant, rotate by half a turn first
   assign fold = angle_i[31] ^ angle_i[30];
   assign x_sh = x_q >>> iter_q;
   assign y_sh = y_q >>> iter_q;

   ////////////////////////////////////////////////////////////
   // Iteration control
   ////////////////////////////////////////////////////////////
   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_o <= 1'b0;
         done_o <= 1'b0;
         iter_q <= '0;
      end else begin
         done_o <= 1'b0;                          // Single cycle pulse
         if (start_i) begin
            busy_o <= 1'b1;
            iter_q <= '0;
         end else if (busy_o) begin
            iter_q <= iter_q + 1'b1;
            if (iter_q == 5'(CORDIC_ITERS - 1)) begin  // Last micro-rotation
               busy_o <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   // Shift-and-add datapath
   always_ff @(posedge hclk_i) begin
      if (start_i) begin
         x_q <= fold ? -CORDIC_GAIN_INIT : CORDIC_GAIN_INIT;  // Negated x and y
         y_q <= '0;
         z_q <= {angle_i[31] ^ fold, angle_i[30:0]};         // Minus half a turn
      end else if (busy_o) begin
         if (!z_q[31]) begin                     // Residual positive
            x_q <= x_q - y_sh;
            y_q <= y_q + x_sh;
            z_q <= z_q - CORDIC_ATAN_TABLE[iter_q[3:0]];
         end else begin
            x_q <= x_q + y_sh;
            y_q <= y_q - x_sh;
            z_q <= z_q + CORDIC_ATAN_TABLE[iter_q[3:0]];
         end
      end
   end

   assign cos_o = x_q;
   assign sin_o = y_q;

endmodule

`default_nettype wire

// File: design/ahb_cordic.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_cordic import subsys_pkg::*; #(
   parameter int CORDIC_ITERS = 16
) (
   input  logic                   hclk_i,
   input  logic                   arst_n_i,
   input  logic                   hsel_i,
   input  logic [HADDR_WIDTH-1:0] haddr_i,
   input  htrans_t                htrans_i,
   input  logic                   hwrite_i,
   input  logic [HDATA_WIDTH-1:0] hwdata_i,
   input  logic                   hready_i,
   output logic [HDATA_WIDTH-1:0] hrdata_o,
   output logic                   hreadyout_o
);

   cordic_state_t          state_q;
   logic                   dp_valid_q, dp_write_q;
   logic [4:0]             dp_reg_q;             // Register offset in data phase
   logic [HDATA_WIDTH-1:0] angle_q, cos_q, sin_q;
   logic                   start, core_busy, core_done, rd_result;
   logic [HDATA_WIDTH-1:0] core_cos, core_sin;

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_valid_q <= 1'b0;
         dp_write_q <= 1'b0;
         dp_reg_q   <= '0;
      end else if (hready_i) begin
         dp_valid_q <= hsel_i && (htrans_i == HTRANS_NONSEQ);
         dp_write_q <= hwrite_i;
         dp_reg_q   <= haddr_i[4:0];
      end
   end

   // ANGLE write completing, dropped while the core runs
   assign start = dp_valid_q && dp_write_q && (dp_reg_q == CORDIC_REG_ANGLE) && hready_i
                  && !core_busy;
   assign rd_result = dp_valid_q && !dp_write_q
                      && (dp_reg_q == CORDIC_REG_COS || dp_reg_q == CORDIC_REG_SIN);
   assign hreadyout_o = !(rd_result && state_q == CRD_BUSY);  // Stall until results latch

   ////////////////////////////////////////////////////////////
   // Front end FSM and result registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= CRD_IDLE;
         angle_q <= '0;
         cos_q   <= '0;
         sin_q   <= '0;
      end else begin
         case (state_q)
            CRD_BUSY: if (core_done && !start) state_q <= CRD_DONE;  // Restart in done cycle
            default:  if (start) state_q <= CRD_BUSY;
         endcase
         if (start) angle_q <= hwdata_i;
         if (core_done) begin
            cos_q <= core_cos;
            sin_q <= core_sin;
         end
      end
   end

   always_comb begin
      case (dp_reg_q)
         CORDIC_REG_ANGLE:  hrdata_o = angle_q;
         CORDIC_REG_STATUS: hrdata_o = {{(HDATA_WIDTH-2){1'b0}},
                                        state_q == CRD_DONE, state_q == CRD_BUSY};
         CORDIC_REG_COS:    hrdata_o = cos_q;
         CORDIC_REG_SIN:    hrdata_o = sin_q;
         default:           hrdata_o = '0;       // Spare offsets
      endcase
   end

   cordic_core #(
      .CORDIC_ITERS ( CORDIC_ITERS ) )
   u_core (
      .hclk_i       ( hclk_i       ),
      .arst_n_i     ( arst_n_i     ),
      .start_i      ( start        ),
      .angle_i      ( hwdata_i     ),
      .busy_o       ( core_busy    ),
      .done_o       ( core_done    ),
      .cos_o        ( core_cos     ),
      .sin_o        ( core_sin     ) );

endmodule

`default_nettype wire

// File: design/ahb_sram.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_sram import subsys_pkg::*; #(
   parameter int SRAM_DEPTH = 512                // Power of two
) (
   input  logic                   hclk_i,
   input  logic                   arst_n_i,
   input  logic                   hsel_i,
   input  logic [HADDR_WIDTH-1:0] haddr_i,
   input  htrans_t                htrans_i,
   input  logic                   hwrite_i,
   input  logic [HDATA_WIDTH-1:0] hwdata_i,
   input  logic                   hready_i,
   output logic [HDATA_WIDTH-1:0] hrdata_o,
   output logic                   hreadyout_o
);

   localparam int AW = $clog2(SRAM_DEPTH);       // Word address bits

   logic [HDATA_WIDTH-1:0] mem [SRAM_DEPTH];
   logic                   dp_we_q;              // Write pending in data phase
   logic [AW-1:0]          dp_addr_q;

   // Capture accepted address phase
   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_we_q   <= 1'b0;
         dp_addr_q <= '0;
      end else if (hready_i) begin
         dp_we_q   <= hsel_i && (htrans_i == HTRANS_NONSEQ) && hwrite_i;
         dp_addr_q <= haddr_i[AW+1:2];           // Byte to word address
      end
   end

   // Write data arrives in the data phase
   always_ff @(posedge hclk_i) begin
      if (dp_we_q && hready_i) mem[dp_addr_q] <= hwdata_i;
   end

   assign hrdata_o    = mem[dp_addr_q];          // Asynchronous read
   assign hreadyout_o = 1'b1;                    // Zero wait states

endmodule

`default_nettype wire

// File: design/ahb_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_decoder import subsys_pkg::*; (
   input  logic                   hclk_i,
   input  logic                   arst_n_i,
   input  logic [HADDR_WIDTH-1:0] haddr_i,
   input  htrans_t                htrans_i,      // Only for the read flag
   input  logic                   hwrite_i,
   output logic                   hready_o,
   output logic [HDATA_WIDTH-1:0] hrdata_o,
   output logic                   data_phase_read_o,
   output logic                   sram_hsel_o,
   output logic                   cordic0_hsel_o,
   output logic                   cordic1_hsel_o,
   input  logic [HDATA_WIDTH-1:0] sram_hrdata_i,
   input  logic [HDATA_WIDTH-1:0] cordic0_hrdata_i,
   input  logic [HDATA_WIDTH-1:0] cordic1_hrdata_i,
   input  logic                   sram_hreadyout_i,
   input  logic                   cordic0_hreadyout_i,
   input  logic                   cordic1_hreadyout_i
);

   slave_idx_t addr_idx;                         // Address phase target
   slave_idx_t dp_idx_q;                         // Data phase target

   // Address match only, transfer type is left to the slaves
   assign sram_hsel_o    = (haddr_i & SRAM_MASK)   == SRAM_BASE;
   assign cordic0_hsel_o = (haddr_i & CORDIC_MASK) == CORDIC0_BASE;
   assign cordic1_hsel_o = (haddr_i & CORDIC_MASK) == CORDIC1_BASE;

   always_comb begin
      if (sram_hsel_o)         addr_idx = SLV_SRAM;
      else if (cordic0_hsel_o) addr_idx = SLV_CORDIC0;
      else if (cordic1_hsel_o) addr_idx = SLV_CORDIC1;
      else                     addr_idx = SLV_NONE;  // Unmapped hole
   end

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         dp_idx_q          <= SLV_NONE;              // Ready high out of reset
         data_phase_read_o <= 1'b0;
      end else if (hready_o) begin                   // Address phase moves on
         dp_idx_q          <= addr_idx;
         data_phase_read_o <= (htrans_i == HTRANS_NONSEQ) && !hwrite_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // Data phase return path
   ////////////////////////////////////////////////////////////
   always_comb begin
      case (dp_idx_q)
         SLV_SRAM:    begin hrdata_o = sram_hrdata_i;    hready_o = sram_hreadyout_i;    end
         SLV_CORDIC0: begin hrdata_o = cordic0_hrdata_i; hready_o = cordic0_hreadyout_i; end
         SLV_CORDIC1: begin hrdata_o = cordic1_hrdata_i; hready_o = cordic1_hreadyout_i; end
         default:     begin hrdata_o = '0;               hready_o = 1'b1;                end
      endcase
   end

endmodule

`default_nettype wire

// File: design/signature_detector.sv
`timescale 1ns/1ps
`default_nettype none

module signature_detector import subsys_pkg::*; (
   input  logic                   hclk_i,
   input  logic                   arst_n_i,
   input  logic                   rd_valid_i,    // Completed read this cycle
   input  logic [HDATA_WIDTH-1:0] rdata_i,
   output logic                   detected_o
);

   det_state_t state_q;

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= DET_IDLE;
      end else if (rd_valid_i) begin              // Only completed reads count
         case (state_q)
            DET_IDLE:
               if (rdata_i == SIGNATURE_FIRST) state_q <= DET_FIRST;
            DET_FIRST: begin
               if (rdata_i == SIGNATURE_SECOND)     state_q <= DET_FOUND;
               else if (rdata_i != SIGNATURE_FIRST) state_q <= DET_IDLE;  // Sequence broken
            end
            DET_FOUND: state_q <= DET_FOUND;     // Sticky until reset
            default:   state_q <= DET_IDLE;
         endcase
      end
   end

   assign detected_o = (state_q == DET_FOUND);

endmodule

`default_nettype wire

// File: design/cordic_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_subsys_top import subsys_pkg::*; #(
   parameter int SRAM_DEPTH   = 512,                 // Words
   parameter int CORDIC_ITERS = 16                   // Micro-rotations per angle
) (
   input  logic                   hclk_i,
   input  logic                   arst_n_i,
   input  logic [HADDR_WIDTH-1:0] haddr_i,
   input  htrans_t                htrans_i,
   input  logic                   hwrite_i,
   input  logic [HDATA_WIDTH-1:0] hwdata_i,
   output logic [HDATA_WIDTH-1:0] hrdata_o,
   output logic                   hready_o,          // Also the shared hready of all slaves
   output logic                   detected_o
);

   ////////////////////////////////////////////////////////////
   // Slave side wires
   ////////////////////////////////////////////////////////////
   logic                   sram_hsel,      cordic0_hsel,      cordic1_hsel;
   logic [HDATA_WIDTH-1:0] sram_hrdata,    cordic0_hrdata,    cordic1_hrdata;
   logic                   sram_hreadyout, cordic0_hreadyout, cordic1_hreadyout;
   logic                   data_phase_read;
   logic                   rd_valid;

   assign rd_valid = data_phase_read & hready_o;      // Read completes on this edge

   ahb_decoder u_decoder (
      .hclk_i              ( hclk_i            ),
      .arst_n_i            ( arst_n_i          ),
      .haddr_i             ( haddr_i           ),
      .htrans_i            ( htrans_i          ),
      .hwrite_i            ( hwrite_i          ),
      .hready_o            ( hready_o          ),
      .hrdata_o            ( hrdata_o          ),
      .data_phase_read_o   ( data_phase_read   ),
      .sram_hsel_o         ( sram_hsel         ),
      .cordic0_hsel_o      ( cordic0_hsel      ),
      .cordic1_hsel_o      ( cordic1_hsel      ),
      .sram_hrdata_i       ( sram_hrdata       ),
      .cordic0_hrdata_i    ( cordic0_hrdata    ),
      .cordic1_hrdata_i    ( cordic1_hrdata    ),
      .sram_hreadyout_i    ( sram_hreadyout    ),
      .cordic0_hreadyout_i ( cordic0_hreadyout ),
      .cordic1_hreadyout_i ( cordic1_hreadyout ) );

   ahb_sram #(
      .SRAM_DEPTH  ( SRAM_DEPTH     ) )
   u_sram (
      .hclk_i      ( hclk_i         ),
      .arst_n_i    ( arst_n_i       ),
      .hsel_i      ( sram_hsel      ),
      .haddr_i     ( haddr_i        ),
      .htrans_i    ( htrans_i       ),
      .hwrite_i    ( hwrite_i       ),
      .hwdata_i    ( hwdata_i       ),
      .hready_i    ( hready_o       ),
      .hrdata_o    ( sram_hrdata    ),
      .hreadyout_o ( sram_hreadyout ) );

   ahb_cordic #(
      .CORDIC_ITERS ( CORDIC_ITERS      ) )
   cordic0 (
      .hclk_i       ( hclk_i            ),
      .arst_n_i     ( arst_n_i          ),
      .hsel_i       ( cordic0_hsel      ),
      .haddr_i      ( haddr_i           ),
      .htrans_i     ( htrans_i          ),
      .hwrite_i     ( hwrite_i          ),
      .hwdata_i     ( hwdata_i          ),
      .hready_i     ( hready_o          ),
      .hrdata_o     ( cordic0_hrdata    ),
      .hreadyout_o  ( cordic0_hreadyout ) );

   ahb_cordic #(
      .CORDIC_ITERS ( CORDIC_ITERS      ) )
   cordic1 (
      .hclk_i       ( hclk_i            ),
      .arst_n_i     ( arst_n_i          ),
      .hsel_i       ( cordic1_hsel      ),
      .haddr_i      ( haddr_i           ),
      .htrans_i     ( htrans_i          ),
      .hwrite_i     ( hwrite_i          ),
      .hwdata_i     ( hwdata_i          ),
      .hready_i     ( hready_o          ),
      .hrdata_o     ( cordic1_hrdata    ),
      .hreadyout_o  ( cordic1_hreadyout ) );

   // Watches the read data returned to the master
   signature_detector u_detector (
      .hclk_i     ( hclk_i     ),
      .arst_n_i   ( arst_n_i   ),
      .rd_valid_i ( rd_valid   ),
      .rdata_i    ( hrdata_o   ),
      .detected_o ( detected_o ) );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int RESET_CYCLES = 16
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;                 // 10 ns period
   end

   // Reset held from time zero, released just after an edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      #1 arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/cordic_subsys_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cordic_subsys_properties #(
   parameter int CORDIC_ITERS = 16
) (
   input logic hclk_i,
   input logic arst_n_i,
   input logic hready_i,
   input logic detected_i,
   input logic sram_hsel_i,
   input logic cordic0_hsel_i,
   input logic cordic1_hsel_i
);

   int fail_cnt = 0;                             // Summed into the final error count
   int low_cnt;                                  // Wait states in a row

   always_ff @(posedge hclk_i or negedge arst_n_i) begin
      if (!arst_n_i)      low_cnt <= 0;
      else if (!hready_i) low_cnt <= low_cnt + 1;
      else                low_cnt <= 0;
   end

   ////////////////////////////////////////////////////////////
   // Bus and detector rules
   ////////////////////////////////////////////////////////////
   hready_bounded: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
      !hready_i |-> low_cnt < CORDIC_ITERS + 2)
      else begin
         fail_cnt++;
         $error("hready low for more than %0d cycles", CORDIC_ITERS + 2);
      end

   detected_sticky: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
      !$fell(detected_i))
      else begin
         fail_cnt++;
         $error("detected output fell outside reset");
      end

   one_select: assert property (@(posedge hclk_i) disable iff (!arst_n_i)
      $onehot0({sram_hsel_i, cordic0_hsel_i, cordic1_hsel_i}))
      else begin
         fail_cnt++;
         $error("more than one slave select high");
      end

endmodule

bind cordic_subsys_top cordic_subsys_properties #(
   .CORDIC_ITERS   ( CORDIC_ITERS ) )
props (
   .hclk_i         ( hclk_i       ),
   .arst_n_i       ( arst_n_i     ),
   .hready_i       ( hready_o     ),
   .detected_i     ( detected_o   ),
   .sram_hsel_i    ( sram_hsel    ),
   .cordic0_hsel_i ( cordic0_hsel ),
   .cordic1_hsel_i ( cordic1_hsel ) );

`default_nettype wire

// File: testbench/tb_cordic_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cordic_subsys import subsys_pkg::*; ();

   localparam int ITERS      = 16;
   localparam int DEPTH      = 512;
   localparam int MAX_CYCLES = 4000;              // About 1100 cycles of traffic plus margin

   logic        hclk, arst_n, hwrite, hready, detected;
   htrans_t     htrans;
   logic [31:0] haddr, hwdata, hrdata;
   logic [31:0] dp_wdata;                         // Write data owed to the data phase
   logic [31:0] last_rdata, rd_v, ang, wd, exp_v;
   logic [63:0] res;                              // {cos, sin}
   logic [31:0] model [logic [31:0]];             // SRAM contents by byte address
   logic [31:0] addr_q [$];
   logic [31:0] exp_q [$];                        // Scoreboard of pending reads
   logic        chk_q [$];
   string       name_q [$];
   logic        chk_v, rd_in_dp;
   string       name_v;
   integer      seed;
   int          i, u, idx;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;

   tb_clock_gen u_clk (
      .clk_o    ( hclk   ),
      .arst_n_o ( arst_n ) );

   cordic_subsys_top #(
      .SRAM_DEPTH   ( DEPTH    ),
      .CORDIC_ITERS ( ITERS    ) )
   uut (
      .hclk_i       ( hclk     ),
      .arst_n_i     ( arst_n   ),
      .haddr_i      ( haddr    ),
      .htrans_i     ( htrans   ),
      .hwrite_i     ( hwrite   ),
      .hwdata_i     ( hwdata   ),
      .hrdata_o     ( hrdata   ),
      .hready_o     ( hready   ),
      .detected_o   ( detected ) );

   ////////////////////////////////////////////////////////////
   // Reference model and checking
   ////////////////////////////////////////////////////////////
   function automatic logic [63:0] cordic_ref(input logic [31:0] angle);
      logic signed [31:0] x, y, z, x_old;
      logic               fold;
      int                 k;
      fold = (angle[31:30] == 2'b01) || (angle[31:30] == 2'b10);   // Left half-plane
      x = fold ? -CORDIC_GAIN_INIT : CORDIC_GAIN_INIT;
      y = '0;
      z = fold ? angle + 32'h8000_0000 : angle;  // Half a turn off
      for (k = 0; k < ITERS; k++) begin
         x_old = x;
         if (z >= 0) begin
            x = x - (y >>> k);
            y = y + (x_old >>> k);
            z = z - CORDIC_ATAN_TABLE[k[3:0]];
         end else begin
            x = x + (y >>> k);
            y = y - (x_old >>> k);
            z = z + CORDIC_ATAN_TABLE[k[3:0]];
         end
      end
      return {x, y};
   endfunction

   function automatic logic [31:0] cordic_addr(input int unit, input logic [4:0] off);
      return (unit == 0 ? CORDIC0_BASE : CORDIC1_BASE) | {27'd0, off};
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp_data,
                              input logic [31:0] act);
      checks++;
      if (act !== exp_data) begin
         errors++;
         $display("error %s: expected %08h, actual %08h", name, exp_data, act);
      end
   endtask

   // Reads complete at the edge after a high-ready negedge
   always @(negedge hclk) begin
      if (hready) begin
         if (rd_in_dp) begin
            if (exp_q.size() == 0) begin
               errors++;
               $display("a read completed with nothing expected in the scoreboard");
            end else begin
               exp_v  = exp_q.pop_front();
               chk_v  = chk_q.pop_front();
               name_v = name_q.pop_front();
               if (chk_v) check_value(name_v, exp_v, hrdata);
            end
         end
         rd_in_dp = (htrans == HTRANS_NONSEQ) && !hwrite;
      end
   end

   always @(posedge hclk) begin
      cycles++;
      if (cycles > MAX_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Bus master
   ////////////////////////////////////////////////////////////
   task automatic wait_ready();
      @(negedge hclk);
      while (!hready) @(negedge hclk);           // Wait states
      last_rdata = hrdata;
      @(posedge hclk);
      #1;
   endtask

   task automatic transfer(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
                           input logic chk, input logic [31:0] exp_data, input string name);
      haddr  = addr;
      htrans = HTRANS_NONSEQ;
      hwrite = wr;
      hwdata = dp_wdata;                         // Belongs to the transfer ahead
      if (!wr) begin
         exp_q.push_back(exp_data);
         chk_q.push_back(chk);
         name_q.push_back(name);
      end
      wait_ready();
      dp_wdata = wdata;
   endtask

   task automatic idle_cycle();
      htrans = HTRANS_IDLE;
      hwrite = 1'b0;
      hwdata = dp_wdata;
      wait_ready();
      dp_wdata = '0;
   endtask

   task automatic read_value(input logic [31:0] addr, output logic [31:0] data);
      transfer(addr, 1'b0, '0, 1'b0, '0, "poll");
      idle_cycle();                              // Lets the data phase finish
      data = last_rdata;
   endtask

   initial begin
      haddr    = '0;
      htrans   = HTRANS_IDLE;
      hwrite   = 1'b0;
      hwdata   = '0;
      dp_wdata = '0;
      rd_in_dp = 1'b0;
      seed     = 29;
      wait (arst_n === 1'b1);
      @(posedge hclk);
      #1;

      // Reset values
      check_value("reset_hready", 32'd1, {31'd0, hready});
      check_value("reset_detected", 32'd0, {31'd0, detected});
      for (u = 0; u < 2; u++) begin
         transfer(cordic_addr(u, CORDIC_REG_STATUS), 1'b0, '0, 1'b1, '0, "reset_status");
         transfer(cordic_addr(u, CORDIC_REG_COS), 1'b0, '0, 1'b1, '0, "reset_cos");
      end
      idle_cycle();

      // SRAM back-to-back writes, then pipelined reads
      for (i = 0; i < 64; i++) begin
         idx = $unsigned($random(seed)) % DEPTH;
         wd  = $random(seed);
         addr_q.push_back(32'(idx * 4));
         model[32'(idx * 4)] = wd;                // Last write wins
         transfer(32'(idx * 4), 1'b1, wd, 1'b0, '0, "");
      end
      foreach (addr_q[k]) transfer(addr_q[k], 1'b0, '0, 1'b1, model[addr_q[k]], "sram_read");
      idle_cycle();

      // COS and SIN read right behind the ANGLE write, stalling on the core
      for (u = 0; u < 2; u++) begin
         for (i = 0; i < 20; i++) begin
            ang = $random(seed);
            res = cordic_ref(ang);
            transfer(cordic_addr(u, CORDIC_REG_ANGLE), 1'b1, ang, 1'b0, '0, "");
            transfer(cordic_addr(u, CORDIC_REG_COS), 1'b0, '0, 1'b1, res[63:32],
                     $sformatf("cordic%0d_cos", u));
            transfer(cordic_addr(u, CORDIC_REG_SIN), 1'b0, '0, 1'b1, res[31:0],
                     $sformatf("cordic%0d_sin", u));
         end
      end
      idle_cycle();

      // STATUS polling, second ANGLE while busy is dropped
      ang = $random(seed);
      res = cordic_ref(ang);
      transfer(cordic_addr(0, CORDIC_REG_ANGLE), 1'b1, ang, 1'b0, '0, "");
      transfer(cordic_addr(0, CORDIC_REG_STATUS), 1'b0, '0, 1'b1, 32'h1, "status_busy");
      transfer(cordic_addr(0, CORDIC_REG_ANGLE), 1'b1, ~ang, 1'b0, '0, "");
      rd_v = '0;
      while (rd_v[1] == 1'b0) read_value(cordic_addr(0, CORDIC_REG_STATUS), rd_v);
      check_value("status_done", 32'h2, rd_v);
      transfer(cordic_addr(0, CORDIC_REG_COS), 1'b0, '0, 1'b1, res[63:32], "status_cos");
      transfer(cordic_addr(0, CORDIC_REG_SIN), 1'b0, '0, 1'b1, res[31:0], "status_sin");
      transfer(cordic_addr(0, CORDIC_REG_ANGLE), 1'b0, '0, 1'b1, ang, "angle_kept");
      idle_cycle();

      // Holes in the map, 0x400 shares SRAM index bits with the hole
      transfer(32'h0000_0400, 1'b1, 32'h1234_5678, 1'b0, '0, "");
      transfer(32'h4000_0400, 1'b1, 32'hDEAD_BEEF, 1'b0, '0, "");
      transfer(32'h4000_0400, 1'b0, '0, 1'b1, '0, "unmapped_read");
      transfer(32'h8000_0000, 1'b0, '0, 1'b1, '0, "unmapped_read");
      transfer(32'h0000_0400, 1'b0, '0, 1'b1, 32'h1234_5678, "unmapped_write");
      idle_cycle();

      // Signature words in SRAM
      transfer(32'h0000_0010, 1'b1, SIGNATURE_FIRST, 1'b0, '0, "");
      transfer(32'h0000_0014, 1'b1, SIGNATURE_SECOND, 1'b0, '0, "");
      transfer(32'h0000_0018, 1'b1, 32'h0000_0000, 1'b0, '0, "");
      check_value("detect_before", 32'd0, {31'd0, detected});
      transfer(32'h0000_0010, 1'b0, '0, 1'b1, SIGNATURE_FIRST, "sig_first");
      transfer(32'h0000_0018, 1'b0, '0, 1'b1, '0, "sig_other");
      idle_cycle();
      check_value("detect_broken", 32'd0, {31'd0, detected});
      transfer(32'h0000_0010, 1'b0, '0, 1'b1, SIGNATURE_FIRST, "sig_first");
      transfer(32'h0000_0014, 1'b0, '0, 1'b1, SIGNATURE_SECOND, "sig_second");
      idle_cycle();
      check_value("detect_found", 32'd1, {31'd0, detected});
      transfer(32'h0000_0018, 1'b1, 32'h0F0F_0F0F, 1'b0, '0, "");
      transfer(32'h0000_0018, 1'b0, '0, 1'b1, 32'h0F0F_0F0F, "sig_after");
      transfer(cordic_addr(1, CORDIC_REG_STATUS), 1'b0, '0, 1'b1, 32'h2, "sig_status");
      repeat (2) idle_cycle();
      check_value("detect_sticky", 32'd1, {31'd0, detected});

      ////////////////////////////////////////////////////////////
      // Closing report
      ////////////////////////////////////////////////////////////
      if (exp_q.size() != 0) begin
         errors++;
         $display("%0d expected reads never completed on the bus", exp_q.size());
      end
      errors += uut.props.fail_cnt;              // Assertion failures
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
design/subsys_pkg.sv
design/cordic_core.sv
design/ahb_cordic.sv
design/ahb_sram.sv
design/ahb_decoder.sv
design/signature_detector.sv
design/cordic_subsys_top.sv
testbench/tb_clock_gen.sv
testbench/cordic_subsys_properties.sv
testbench/tb_cordic_subsys.sv

// File: Makefile
TOP := tb_cordic_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
